//--- Bender.yml
package:
  name: hps_sys

sources:
  - include_dirs:
      - source
    files:
      - source/hps_sys_pkg.sv
      - source/hps_cmd_decoder.sv
      - source/panel_io.sv
      - source/audio_mix_channel.sv
      - source/hps_sys_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/hps_sys_sva.sv
      - tb/hps_sys_tb.sv

//--- source/audio_mix_channel.sv
// One stereo side; core audio must hold for three clocks and the output lags it by nine
`timescale 1ns/1ps
`include "hps_sys_macros.svh"

module audio_mix_channel
	import hps_sys_pkg::*;
(
	input  logic                  clk,
	input  logic                  resetd,
	input  sample_t               i_core,
	input  sample_t               i_host,
	input  sample_t               i_pre_in,
	input  mix_mode_e             i_mix,
	input  logic                  i_signed,
	input  logic [`HPS_ATT_W-1:0] i_att,
	output sample_t               o_pre_out,
	output sample_t               o_sample
);

	localparam int SW    = `HPS_SAMPLE_W;
	localparam int SUM_W = SW + 1;

	sample_t                 core_d1;
	sample_t                 core_d2;
	sample_t                 core_d3;
	sample_t                 core_held;
	logic signed [SUM_W-1:0] host_ext;
	logic signed [SUM_W-1:0] pre_ext;
	logic signed [SUM_W-1:0] conv;
	logic signed [SUM_W-1:0] sum;
	logic signed [SUM_W-1:0] mixed;
	logic signed [SUM_W-1:0] atten;

	assign host_ext = $signed({i_host[SW-1], i_host});
	assign pre_ext  = $signed({i_pre_in[SW-1], i_pre_in});

	//////////////////////////////////////////////////
	// Sample-hold filter
	//////////////////////////////////////////////////

	// Rejects values that flicker while the core updates its word
	always_ff @(posedge clk) begin
		if (resetd) begin
			core_d1   <= '0;
			core_d2   <= '0;
			core_d3   <= '0;
			core_held <= '0;
		end else begin
			core_d1 <= i_core;
			core_d2 <= core_d1;
			core_d3 <= core_d2;
			if (core_d1 == core_d2 && core_d2 == core_d3)
				core_held <= core_d3;
		end
	end

	//////////////////////////////////////////////////
	// Mix pipeline
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			conv      <= '0;
			sum       <= '0;
			mixed     <= '0;
			o_pre_out <= '0;
			atten     <= '0;
			o_sample  <= '0;
		end else begin
			// Unsigned audio is halved to fit the signed range
			if (i_signed)
				conv <= $signed({core_held[SW-1], core_held});
			else
				conv <= $signed({2'b00, core_held[SW-1:1]});

			sum       <= conv + host_ext;
			o_pre_out <= sum[SUM_W-1:1];

			case (i_mix)
				MIX_NONE: mixed <= sum;
				MIX_25:   mixed <= sum - (sum >>> 3) + (pre_ext >>> 2);
				MIX_50:   mixed <= sum - (sum >>> 2) + (pre_ext >>> 1);
				MIX_FULL: mixed <= (sum >>> 1) + pre_ext;
			endcase

			// Top attenuation bit mutes
			if (i_att[`HPS_ATT_W-1])
				atten <= '0;
			else
				atten <= mixed >>> i_att[`HPS_ATT_W-2:0];

			// Clamp to the 16-bit signed range
			if (atten[SUM_W-1] != atten[SUM_W-2])
				o_sample <= {atten[SUM_W-1], {(SW-1){atten[SW-1]}}};
			else
				o_sample <= atten[SW-1:0];
		end
	end

endmodule

//--- source/hps_cmd_decoder.sv
// Host paces the words with no back-pressure; only LED and volume frames change state
`timescale 1ns/1ps
`include "hps_sys_macros.svh"

module hps_cmd_decoder
	import hps_sys_pkg::*;
(
	input  logic                   clk,
	input  logic                   resetd,
	input  logic                   i_io_sel,
	input  logic                   i_io_strobe,
	input  logic [`HPS_WORD_W-1:0] i_io_din,
	output logic [`HPS_LED_W-1:0]  o_led_overtake,
	output logic [`HPS_LED_W-1:0]  o_led_state,
	output logic [`HPS_ATT_W-1:0]  o_vol_att
);

	localparam int CMD_W = $bits(hps_cmd_e);

	hps_cmd_e cmd;
	hps_cmd_e cmd_decoded;
	logic     has_cmd;
	logic     cmd_word;
	logic     data_word;

	//////////////////////////////////////////////////
	// Frame tracking
	//////////////////////////////////////////////////

	// First strobe in a frame is the command word
	assign cmd_word  = i_io_sel && i_io_strobe && !has_cmd;
	assign data_word = i_io_sel && i_io_strobe && has_cmd;

	// Codes we do not handle collapse to CMD_NONE so their data is swallowed
	always_comb begin
		case (i_io_din[CMD_W-1:0])
			CMD_LED:    cmd_decoded = CMD_LED;
			CMD_VOLUME: cmd_decoded = CMD_VOLUME;
			default:    cmd_decoded = CMD_NONE;
		endcase
	end

	// Dropping the select ends the frame
	always_ff @(posedge clk) begin
		if (resetd || !i_io_sel) begin
			has_cmd <= 1'b0;
			cmd     <= CMD_NONE;
		end else if (cmd_word) begin
			has_cmd <= 1'b1;
			cmd     <= cmd_decoded;
		end
	end

	//////////////////////////////////////////////////
	// Registers written by data words
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_led_overtake <= '0;
			o_led_state    <= '0;
			o_vol_att      <= '0;
		end else if (data_word) begin
			case (cmd)
				CMD_LED: begin
					// High byte picks the overridden LEDs, low byte their level
					o_led_overtake <= i_io_din[`HPS_WORD_W-1 -: `HPS_LED_W];
					o_led_state    <= i_io_din[`HPS_LED_W-1:0];
				end
				CMD_VOLUME: begin
					o_vol_att <= i_io_din[`HPS_ATT_W-1:0];
				end
				default: begin
					// Nothing to update
				end
			endcase
		end
	end

endmodule

//--- source/hps_sys_macros.svh
// Shared widths and defaults; the divider default assumes a clock near 50 MHz
`ifndef HPS_SYS_MACROS_SVH
`define HPS_SYS_MACROS_SVH

// Host word and audio sample widths
`define HPS_WORD_W      16
`define HPS_SAMPLE_W    16

// Volume field with mute in its top bit
`define HPS_ATT_W       5

// Button debounce history and sample divider
`define HPS_DEB_DEPTH   8
`define HPS_DEB_DIV     100000

// Main-board LED byte
`define HPS_LED_W       8

// Status LED positions in the LED byte
`define HPS_LED_POWER_BIT 4
`define HPS_LED_DISK_BIT  2
`define HPS_LED_USER_BIT  0

`endif

//--- source/hps_sys_pkg.sv
// Command codes and mixer types; only the LED and volume commands are decoded
`include "hps_sys_macros.svh"

package hps_sys_pkg;

	// Host commands handled here
	typedef enum logic [7:0] {
		CMD_NONE   = 8'h00,
		CMD_LED    = 8'h25,
		CMD_VOLUME = 8'h26
	} hps_cmd_e;

	// Cross mix between left and right channels
	typedef enum logic [1:0] {
		MIX_NONE = 2'd0,
		MIX_25   = 2'd1,
		MIX_50   = 2'd2,
		MIX_FULL = 2'd3
	} mix_mode_e;

	// Raw audio word, signedness decided per channel
	typedef logic [`HPS_SAMPLE_W-1:0] sample_t;

endpackage

//--- source/hps_sys_top.sv
// Single clock domain; DEB_DIV must suit the clock rate for a useful debounce time
`timescale 1ns/1ps
`include "hps_sys_macros.svh"

module hps_sys_top
	import hps_sys_pkg::*;
#(
	parameter int DEB_DIV = `HPS_DEB_DIV
) (
	input  logic                   clk,
	input  logic                   resetd,
	input  logic                   i_io_sel,
	input  logic                   i_io_strobe,
	input  logic [`HPS_WORD_W-1:0] i_io_din,
	input  logic [1:0]             i_btn_n,
	input  logic [2:0]             i_led_status,
	input  sample_t                i_audio_l,
	input  sample_t                i_audio_r,
	input  sample_t                i_host_l,
	input  sample_t                i_host_r,
	input  mix_mode_e              i_audio_mix,
	input  logic                   i_audio_signed,
	output logic [`HPS_LED_W-1:0]  o_led,
	output logic                   o_btn_user,
	output logic                   o_btn_osd,
	output sample_t                o_audio_l,
	output sample_t                o_audio_r
);

	logic [`HPS_LED_W-1:0] led_overtake;
	logic [`HPS_LED_W-1:0] led_state;
	logic [`HPS_ATT_W-1:0] vol_att;
	sample_t               pre_l;
	sample_t               pre_r;

	//////////////////////////////////////////////////
	// Host command channel and panel
	//////////////////////////////////////////////////

	hps_cmd_decoder u_decoder (
		.clk            (clk),
		.resetd         (resetd),
		.i_io_sel       (i_io_sel),
		.i_io_strobe    (i_io_strobe),
		.i_io_din       (i_io_din),
		.o_led_overtake (led_overtake),
		.o_led_state    (led_state),
		.o_vol_att      (vol_att)
	);

	panel_io #(
		.DIV_PERIOD (DEB_DIV)
	) u_panel (
		.clk            (clk),
		.resetd         (resetd),
		.i_btn_n        (i_btn_n),
		.i_led_status   (i_led_status),
		.i_led_overtake (led_overtake),
		.i_led_state    (led_state),
		.o_btn_user     (o_btn_user),
		.o_btn_osd      (o_btn_osd),
		.o_led          (o_led)
	);

	//////////////////////////////////////////////////
	// Audio, pre sums crossed between sides
	//////////////////////////////////////////////////

	audio_mix_channel u_mix_l (
		.clk       (clk),
		.resetd    (resetd),
		.i_core    (i_audio_l),
		.i_host    (i_host_l),
		.i_pre_in  (pre_r),
		.i_mix     (i_audio_mix),
		.i_signed  (i_audio_signed),
		.i_att     (vol_att),
		.o_pre_out (pre_l),
		.o_sample  (o_audio_l)
	);

	audio_mix_channel u_mix_r (
		.clk       (clk),
		.resetd    (resetd),
		.i_core    (i_audio_r),
		.i_host    (i_host_r),
		.i_pre_in  (pre_l),
		.i_mix     (i_audio_mix),
		.i_signed  (i_audio_signed),
		.i_att     (vol_att),
		.o_pre_out (pre_r),
		.o_sample  (o_audio_r)
	);

endmodule

//--- source/panel_io.sv
// Buttons are active low and asynchronous; DIV_PERIOD sets the sample spacing in clocks
`timescale 1ns/1ps
`include "hps_sys_macros.svh"

module panel_io #(
	parameter int DIV_PERIOD = `HPS_DEB_DIV
) (
	input  logic                  clk,
	input  logic                  resetd,
	input  logic [1:0]            i_btn_n,
	input  logic [2:0]            i_led_status,
	input  logic [`HPS_LED_W-1:0] i_led_overtake,
	input  logic [`HPS_LED_W-1:0] i_led_state,
	output logic                  o_btn_user,
	output logic                  o_btn_osd,
	output logic [`HPS_LED_W-1:0] o_led
);

	localparam int CNT_W = (DIV_PERIOD > 1) ? $clog2(DIV_PERIOD) : 1;

	logic [CNT_W-1:0]                    div_cnt;
	logic                                sample_tick;
	logic [1:0]                          btn_meta;
	logic [1:0]                          btn_sync;
	logic [1:0][`HPS_DEB_DEPTH-1:0]      deb_hist;
	logic [1:0][`HPS_DEB_DEPTH-1:0]      deb_next;
	logic [1:0]                          btn_q;
	logic [`HPS_LED_W-1:0]               status_pat;

	//////////////////////////////////////////////////
	// Button debounce
	//////////////////////////////////////////////////

	assign sample_tick = (div_cnt == CNT_W'(DIV_PERIOD - 1));

	// History after this tick's sample, bit 0 user and bit 1 osd
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			deb_next[i] = {deb_hist[i][`HPS_DEB_DEPTH-2:0], btn_sync[i]};
		end
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			div_cnt  <= '0;
			btn_meta <= '0;
			btn_sync <= '0;
			deb_hist <= '0;
			btn_q    <= '0;
		end else begin
			// Two-flop sync, stored as pressed = 1
			btn_meta <= ~i_btn_n;
			btn_sync <= btn_meta;
			div_cnt  <= sample_tick ? '0 : div_cnt + 1'b1;
			if (sample_tick) begin
				deb_hist <= deb_next;
				for (int i = 0; i < 2; i++) begin
					if (&deb_next[i])
						btn_q[i] <= 1'b1;
					else if (deb_next[i] == '0)
						btn_q[i] <= 1'b0;
				end
			end
		end
	end

	assign o_btn_user = btn_q[0];
	assign o_btn_osd  = btn_q[1];

	//////////////////////////////////////////////////
	// Main-board LEDs
	//////////////////////////////////////////////////

	// Status order is power, disk, user from the top bit down
	always_comb begin
		status_pat                    = '0;
		status_pat[`HPS_LED_POWER_BIT] = i_led_status[2];
		status_pat[`HPS_LED_DISK_BIT]  = i_led_status[1];
		status_pat[`HPS_LED_USER_BIT]  = i_led_status[0];
	end

	assign o_led = (i_led_overtake & i_led_state) | (~i_led_overtake & status_pat);

endmodule

//--- tb/hps_sys_sva.sv
// Bound into the decoder and both mixer channels; ports a binding does not use are tied to zero
`timescale 1ns/1ps
`include "hps_sys_macros.svh"

module hps_sys_sva (
	input logic                      clk,
	input logic                      resetd,
	input logic                      io_sel,
	input logic                      io_strobe,
	input logic [`HPS_ATT_W-1:0]     vol_att,
	input logic [2*`HPS_LED_W-1:0]   led_regs,
	input logic [`HPS_ATT_W-1:0]     att,
	input logic [`HPS_SAMPLE_W-1:0]  sample
);

	//////////////////////////////////////////////////
	// Decoder and mixer properties
	//////////////////////////////////////////////////

	// Volume only moves after a host word
	assert property (@(posedge clk) disable iff (resetd)
		$changed(vol_att) |-> $past(io_sel && io_strobe))
		else $error("attenuation changed without a host strobe");

	// Mute drains the pipeline within six clocks
	assert property (@(posedge clk) disable iff (resetd)
		att[`HPS_ATT_W-1] [*6] |-> sample == '0)
		else $error("output not silent while muted");

	assert property (@(posedge clk)
		resetd |=> (vol_att == '0 && led_regs == '0 && sample == '0))
		else $error("registers not cleared by reset");

endmodule

bind hps_cmd_decoder hps_sys_sva u_sva (
	.clk       (clk),
	.resetd    (resetd),
	.io_sel    (i_io_sel),
	.io_strobe (i_io_strobe),
	.vol_att   (o_vol_att),
	.led_regs  ({o_led_overtake, o_led_state}),
	.att       ('0),
	.sample    ('0)
);

bind audio_mix_channel hps_sys_sva u_sva (
	.clk       (clk),
	.resetd    (resetd),
	.io_sel    (1'b0),
	.io_strobe (1'b0),
	.vol_att   ('0),
	.led_regs  ('0),
	.att       (i_att),
	.sample    (o_sample)
);

//--- tb/hps_sys_tb.sv
// Runs with DEB_DIV of 4; audio is checked only after inputs have held steady for 16 clocks
`timescale 1ns/1ps
`include "hps_sys_macros.svh"

module hps_sys_tb
	import hps_sys_pkg::*;
();

	localparam int DEB_DIV   = 4;
	localparam int SETTLE    = 16;
	localparam int BTN_LIMIT = (`HPS_DEB_DEPTH + 2) * DEB_DIV + 8;
	localparam int MAX_ROWS  = 24;

	typedef struct packed {
		logic [7:0]             cmd;
		logic [`HPS_WORD_W-1:0] data;
		logic [2:0]             status;
		sample_t                core_l;
		sample_t                core_r;
		sample_t                host_l;
		sample_t                host_r;
		logic [1:0]             mix;
		logic                   sgn;
		logic                   use_model;
		logic [`HPS_LED_W-1:0]  exp_led;
		sample_t                exp_l;
		sample_t                exp_r;
	} row_t;

	logic                   clk;
	logic                   resetd;
	logic                   io_sel;
	logic                   io_strobe;
	logic [`HPS_WORD_W-1:0] io_din;
	logic [1:0]             btn_n;
	logic [2:0]             led_status;
	sample_t                audio_l;
	sample_t                audio_r;
	sample_t                host_l;
	sample_t                host_r;
	mix_mode_e              audio_mix;
	logic                   audio_signed;
	logic [`HPS_LED_W-1:0]  led;
	logic                   btn_user;
	logic                   btn_osd;
	logic [1:0]             btn_out;
	sample_t                out_l;
	sample_t                out_r;

	row_t                   rows [0:MAX_ROWS-1];
	int                     nrows;
	int                     mismatches;
	int                     timeouts;
	integer                 seed;
	logic [`HPS_ATT_W-1:0]  att_shadow;

	assign btn_out = {btn_osd, btn_user};

	hps_sys_top #(
		.DEB_DIV (DEB_DIV)
	) uut (
		.clk            (clk),
		.resetd         (resetd),
		.i_io_sel       (io_sel),
		.i_io_strobe    (io_strobe),
		.i_io_din       (io_din),
		.i_btn_n        (btn_n),
		.i_led_status   (led_status),
		.i_audio_l      (audio_l),
		.i_audio_r      (audio_r),
		.i_host_l       (host_l),
		.i_host_r       (host_r),
		.i_audio_mix    (audio_mix),
		.i_audio_signed (audio_signed),
		.o_led          (led),
		.o_btn_user     (btn_user),
		.o_btn_osd      (btn_osd),
		.o_audio_l      (out_l),
		.o_audio_r      (out_r)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Unsigned audio is halved into the signed range
	function automatic int conv_in(input sample_t s, input logic sgn);
		if (sgn)
			return int'($signed(s));
		return int'(s >> 1);
	endfunction

	function automatic sample_t model_out(input sample_t core, input sample_t host,
			input sample_t core_o, input sample_t host_o, input logic [1:0] mix,
			input logic sgn, input logic [`HPS_ATT_W-1:0] att);
		int sum;
		int pre;
		int mixed;
		int val;
		sum = conv_in(core, sgn) + int'($signed(host));
		// Other side's pre sum is its own sum halved
		pre = (conv_in(core_o, sgn) + int'($signed(host_o))) >>> 1;
		case (mix)
			2'd0: mixed = sum;
			2'd1: mixed = sum - (sum >>> 3) + (pre >>> 2);
			2'd2: mixed = sum - (sum >>> 2) + (pre >>> 1);
			default: mixed = (sum >>> 1) + pre;
		endcase
		val = att[`HPS_ATT_W-1] ? 0 : (mixed >>> att[`HPS_ATT_W-2:0]);
		if (val > 32767)
			val = 32767;
		else if (val < -32768)
			val = -32768;
		return val[15:0];
	endfunction

	function automatic logic [`HPS_LED_W-1:0] status_led(input logic [2:0] s);
		logic [`HPS_LED_W-1:0] p;
		p = '0;
		p[`HPS_LED_POWER_BIT] = s[2];
		p[`HPS_LED_DISK_BIT]  = s[1];
		p[`HPS_LED_USER_BIT]  = s[0];
		return p;
	endfunction

	//////////////////////////////////////////////////
	// Stimulus and checks
	//////////////////////////////////////////////////

	task automatic add_row(input logic [7:0] cmd, input logic [15:0] data,
			input logic [2:0] status, input sample_t cl, input sample_t cr,
			input sample_t hl, input sample_t hr, input logic [1:0] mix, input logic sgn,
			input logic use_model, input logic [7:0] eled, input sample_t el,
			input sample_t er);
		row_t r;
		r = {cmd, data, status, cl, cr, hl, hr, mix, sgn, use_model, eled, el, er};
		rows[nrows] = r;
		nrows++;
	endtask

	task automatic build_table();
		logic [1:0] mix;
		logic [2:0] st;
		int         vol;
		// LED override, unknown command, override cleared
		add_row(8'h00, 16'h0000, 3'b111, 0, 0, 0, 0, 2'd0, 1'b1, 1'b1, 8'h15, 0, 0);
		add_row(CMD_LED, 16'hf0a5, 3'b101, 0, 0, 0, 0, 2'd0, 1'b1, 1'b1, 8'ha1, 0, 0);
		add_row(8'h31, 16'hffff, 3'b101, 0, 0, 0, 0, 2'd0, 1'b1, 1'b1, 8'ha1, 0, 0);
		add_row(CMD_LED, 16'h0000, 3'b010, 0, 0, 0, 0, 2'd0, 1'b1, 1'b1, 8'h04, 0, 0);
		// Shift by two, then mute
		add_row(CMD_VOLUME, 16'h0002, 3'b010, 16'h1000, 16'hf000, 16'h0100, 16'h0000,
			2'd0, 1'b1, 1'b1, 8'h04, 0, 0);
		add_row(CMD_VOLUME, 16'h0013, 3'b010, 16'h1000, 16'hf000, 16'h0100, 16'h0000,
			2'd0, 1'b1, 1'b0, 8'h04, 16'h0000, 16'h0000);
		// Both clamp limits at full scale
		add_row(CMD_VOLUME, 16'h0000, 3'b010, 16'h7fff, 16'h8000, 16'h7fff, 16'h8000,
			2'd0, 1'b1, 1'b0, 8'h04, 16'h7fff, 16'h8000);
		for (int i = 0; i < 16; i++) begin
			mix = i[1:0];
			st  = $random(seed);
			vol = {$random(seed)} % 3;
			add_row((i % 3 == 0) ? CMD_VOLUME : CMD_NONE, vol[15:0], st,
				$random(seed), $random(seed), $random(seed), $random(seed), mix,
				$random(seed), 1'b1, status_led(st), 0, 0);
		end
	endtask

	task automatic check_value(input string what, input logic [15:0] got,
			input logic [15:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic send_frame(input logic [7:0] cmd, input logic [15:0] data);
		@(negedge clk) io_sel = 1'b1;
		@(negedge clk) io_strobe = 1'b1;
		io_din = {8'h00, cmd};
		@(negedge clk) io_strobe = 1'b0;
		@(negedge clk) io_strobe = 1'b1;
		io_din = data;
		@(negedge clk) io_strobe = 1'b0;
		@(negedge clk) io_sel = 1'b0;
	endtask

	task automatic settle(input int cycles);
		repeat (cycles) @(negedge clk);
	endtask

	task automatic wait_button(input int idx, input logic level);
		int n;
		n = 0;
		while (btn_out[idx] !== level && n < BTN_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (btn_out[idx] !== level) begin
			timeouts++;
			$display("timeout: button %0d output never reached %0b within %0d cycles",
				idx, level, BTN_LIMIT);
		end
	endtask

	task automatic apply_row(input int idx);
		row_t r;
		r = rows[idx];
		if (r.cmd != CMD_NONE)
			send_frame(r.cmd, r.data);
		if (r.cmd == CMD_VOLUME)
			att_shadow = r.data[`HPS_ATT_W-1:0];
		@(negedge clk);
		led_status   = r.status;
		audio_l      = r.core_l;
		audio_r      = r.core_r;
		host_l       = r.host_l;
		host_r       = r.host_r;
		audio_mix    = mix_mode_e'(r.mix);
		audio_signed = r.sgn;
		settle(SETTLE);
		if (r.use_model) begin
			r.exp_l = model_out(r.core_l, r.host_l, r.core_r, r.host_r, r.mix, r.sgn,
				att_shadow);
			r.exp_r = model_out(r.core_r, r.host_r, r.core_l, r.host_l, r.mix, r.sgn,
				att_shadow);
		end
		check_value($sformatf("row %0d o_led", idx), led, r.exp_led);
		check_value($sformatf("row %0d o_audio_l", idx), out_l, r.exp_l);
		check_value($sformatf("row %0d o_audio_r", idx), out_r, r.exp_r);
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		resetd       = 1'b1;
		io_sel       = 1'b0;
		io_strobe    = 1'b0;
		io_din       = '0;
		btn_n        = 2'b11;
		led_status   = 3'b111;
		audio_l      = '0;
		audio_r      = '0;
		host_l       = '0;
		host_r       = '0;
		audio_mix    = MIX_NONE;
		audio_signed = 1'b1;
		seed         = 32'hfc61550f;
		nrows        = 0;
		mismatches   = 0;
		timeouts     = 0;
		att_shadow   = '0;

		repeat (8) @(posedge clk);
		@(negedge clk) resetd = 1'b0;
		@(negedge clk);

		check_value("o_led after reset", led, 16'h0015);
		check_value("o_btn_user after reset", btn_user, 0);
		check_value("o_btn_osd after reset", btn_osd, 0);
		check_value("o_audio_l after reset", out_l, 0);
		check_value("o_audio_r after reset", out_r, 0);

		build_table();
		for (int i = 0; i < nrows; i++)
			apply_row(i);

		// User button, then osd button
		for (int b = 0; b < 2; b++) begin
			@(negedge clk) btn_n[b] = 1'b0;
			wait_button(b, 1'b1);
			check_value("idle button output", btn_out[1-b], 0);
			@(negedge clk) btn_n[b] = 1'b1;
			wait_button(b, 1'b0);
		end

		$display("%0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+source
source/hps_sys_pkg.sv
source/hps_cmd_decoder.sv
source/panel_io.sv
source/audio_mix_channel.sv
source/hps_sys_top.sv
tb/hps_sys_sva.sv
tb/hps_sys_tb.sv
